//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= tb_counter_timer
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_TEXT := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@if grep -q "$(PASS_TEXT)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		cat $(LOG); \
		echo "Simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- list.f
+incdir+testbench
src/timer_pkg.sv
src/timer_bus_decode.sv
src/counter_timer_low.sv
src/counter_timer_high.sv
src/counter_timer_top.sv
testbench/tb_counter_timer.sv

//--- src/counter_timer_high.sv
`timescale 1ns/1ps

// High 32 bits of the timer, or a standalone 32-bit timer when unchained
module counter_timer_high import timer_pkg::*; (
    input  logic       clkin,
    input  logic       resetn,
    input  timer_wr_t  wr_i,
    output timer_rd_t  rd_o,
    input  low_link_t  link_i,
    output high_link_t link_o,
    output logic       irq_o
);

    timer_cfg_t cfg;
    word_t      value_reset;
    word_t      value_cur;
    word_t      next_val;
    word_t      start_val;
    word_t      term_val;
    logic       loc_enable;
    logic       last_enable;
    logic       step;          // Count advances this cycle
    logic       stop_flag;
    logic       stop_prev;

    assign rd_o.cfg_rd = {27'd0, cfg};
    assign rd_o.val_rd = value_reset;
    assign rd_o.dat_rd = value_cur;

    always_ff @(posedge clkin or negedge resetn) begin
        if (!resetn) begin
            cfg <= '0;
        end else if (wr_i.cfg_we) begin
            cfg <= timer_cfg_t'(wr_i.wdata[4:0]);
        end
    end

    // Reload value
    always_ff @(posedge clkin or negedge resetn) begin
        if (!resetn) begin
            value_reset <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (wr_i.val_we[i]) begin
                    value_reset[8*i +: 8] <= wr_i.wdata[8*i +: 8];
                end
            end
        end
    end

    assign loc_enable = cfg.chain ? (cfg.enable && link_i.enable) : cfg.enable;
    assign step       = cfg.chain ? link_i.strobe : 1'b1;   // Chained: only on low rollover

    assign next_val  = cfg.updown ? value_cur + 32'd1 : value_cur - 32'd1;
    assign start_val = cfg.updown ? '0 : value_reset;

    // Up-count stop value, one lower when the low word rolls over with us
    assign term_val = !cfg.updown ? '0 :
                      (cfg.chain && link_i.is_offset) ? value_reset - 32'd1 :
                      value_reset;

    assign link_o.stop   = stop_flag;    // Level, held between strobes
    assign link_o.enable = cfg.enable;

    always_ff @(posedge clkin or negedge resetn) begin
        if (!resetn) begin
            value_cur   <= '0;
            last_enable <= 1'b0;
            stop_flag   <= 1'b0;
        end else begin
            last_enable <= loc_enable;
            if (|wr_i.dat_we) begin
                for (int i = 0; i < 4; i++) begin
                    if (wr_i.dat_we[i]) begin
                        value_cur[8*i +: 8] <= wr_i.wdata[8*i +: 8];
                    end
                end
            end else if (loc_enable) begin
                if (!last_enable) begin
                    value_cur <= start_val;
                    stop_flag <= 1'b0;
                end else if (step) begin
                    if (value_cur == term_val) begin
                        if (!cfg.oneshot) begin
                            value_cur <= start_val;
                            stop_flag <= 1'b0;
                        end else begin
                            stop_flag <= 1'b1;
                        end
                    end else begin
                        value_cur <= next_val;
                        stop_flag <= (next_val == term_val);
                    end
                end
            end
        end
    end

    // irq follows the stop rise by one cycle
    always_ff @(posedge clkin or negedge resetn) begin
        if (!resetn) begin
            stop_prev <= 1'b0;
            irq_o     <= 1'b0;
        end else begin
            stop_prev <= stop_flag;
            irq_o     <= cfg.irq_ena && stop_flag && !stop_prev;
        end
    end

    // Chained high word moves only on a low word strobe
    a_chain_step: assert property (@(posedge clkin) disable iff (!resetn)
        (cfg.chain && last_enable && !link_i.strobe && !(|wr_i.dat_we))
        |=> $stable(value_cur));

endmodule

//--- src/counter_timer_low.sv
`timescale 1ns/1ps

// Low 32 bits of the timer, or a standalone 32-bit timer when unchained
module counter_timer_low import timer_pkg::*; (
    input  logic       clkin,
    input  logic       resetn,
    input  timer_wr_t  wr_i,
    output timer_rd_t  rd_o,
    input  high_link_t link_i,
    output low_link_t  link_o,
    output logic       irq_o
);

    timer_cfg_t cfg;
    word_t      value_reset;   // Reload / stop value
    word_t      value_cur;
    word_t      next_val;
    word_t      start_val;
    word_t      term_val;
    word_t      strobe_val;
    logic       loc_enable;
    logic       last_enable;   // Catches the first enabled cycle
    logic       stop_ok;
    logic       at_term;
    logic       next_term;
    logic       stop_flag;
    logic       stop_prev;
    logic       strobe;

    assign rd_o.cfg_rd = {27'd0, cfg};
    assign rd_o.val_rd = value_reset;
    assign rd_o.dat_rd = value_cur;

    // Configuration register
    always_ff @(posedge clkin or negedge resetn) begin
        if (!resetn) begin
            cfg <= '0;
        end else if (wr_i.cfg_we) begin
            cfg <= timer_cfg_t'(wr_i.wdata[4:0]);
        end
    end

    // Reload value, byte lane writes
    always_ff @(posedge clkin or negedge resetn) begin
        if (!resetn) begin
            value_reset <= '0;
        end else begin
            for (int i = 0; i < 4; i++) begin
                if (wr_i.val_we[i]) begin
                    value_reset[8*i +: 8] <= wr_i.wdata[8*i +: 8];
                end
            end
        end
    end

    // Chained: both words must be enabled
    assign loc_enable = cfg.chain ? (cfg.enable && link_i.enable) : cfg.enable;

    // Chained: only stop once the high word is at its end too
    assign stop_ok = cfg.chain ? link_i.stop : 1'b1;

    assign next_val   = cfg.updown ? value_cur + 32'd1 : value_cur - 32'd1;
    assign start_val  = cfg.updown ? '0 : value_reset;
    assign term_val   = cfg.updown ? value_reset : '0;
    assign strobe_val = cfg.updown ? '1 : 32'd2;   // Two cycles ahead of rollover
    assign at_term    = stop_ok && (value_cur == term_val);
    assign next_term  = stop_ok && (next_val == term_val);

    // Up-counting with a zero stop value rolls over together with the
    // high word, so the high word has to stop one step earlier
    assign link_o.is_offset = cfg.updown && (value_reset == '0);
    assign link_o.strobe    = strobe;
    assign link_o.enable    = cfg.enable;

    // Counter
    always_ff @(posedge clkin or negedge resetn) begin
        if (!resetn) begin
            value_cur   <= '0;
            last_enable <= 1'b0;
            stop_flag   <= 1'b0;
            strobe      <= 1'b0;
        end else begin
            last_enable <= loc_enable;
            strobe      <= 1'b0;                       // One cycle wide
            if (|wr_i.dat_we) begin                    // Bus write wins over counting
                for (int i = 0; i < 4; i++) begin
                    if (wr_i.dat_we[i]) begin
                        value_cur[8*i +: 8] <= wr_i.wdata[8*i +: 8];
                    end
                end
            end else if (loc_enable) begin
                if (!last_enable) begin
                    value_cur <= start_val;            // First enabled cycle
                    stop_flag <= 1'b0;
                end else begin
                    strobe <= cfg.chain && (value_cur == strobe_val);
                    if (at_term) begin
                        if (!cfg.oneshot) begin
                            value_cur <= start_val;    // Continuous restart
                            stop_flag <= 1'b0;
                        end else begin
                            stop_flag <= 1'b1;         // Hold at terminal
                        end
                    end else begin
                        value_cur <= next_val;
                        stop_flag <= next_term;
                    end
                end
            end
        end
    end

    // Interrupt on the rising edge of the stop condition
    always_ff @(posedge clkin or negedge resetn) begin
        if (!resetn) begin
            stop_prev <= 1'b0;
            irq_o     <= 1'b0;
        end else begin
            stop_prev <= stop_flag;
            irq_o     <= cfg.irq_ena && stop_flag && !stop_prev;
        end
    end

    // A held one-shot stop must not retrigger the interrupt
    a_irq_pulse: assert property (@(posedge clkin) disable iff (!resetn)
        irq_o |=> !irq_o);

endmodule

//--- src/counter_timer_top.sv
`timescale 1ns/1ps

// Two-word counter-timer on a Wishbone slave port
module counter_timer_top import timer_pkg::*; (
    input  logic       clkin,
    input  logic       resetn,
    input  adr_t       wb_adr_i,
    input  word_t      wb_dat_i,
    input  byte_en_t   wb_sel_i,
    input  logic       wb_we_i,
    input  logic       wb_cyc_i,
    input  logic       wb_stb_i,
    output logic       wb_ack_o,
    output word_t      wb_dat_o,
    output logic [1:0] irq_o        // Bit 0 low timer, bit 1 high timer
);

    timer_wr_t  low_wr;
    timer_wr_t  high_wr;
    timer_rd_t  low_rd;
    timer_rd_t  high_rd;
    low_link_t  low_link;   // Strobe and offset up to the high word
    high_link_t high_link;  // Stop level back to the low word

    timer_bus_decode #(
        .base_adr (BASE_ADR)
    ) i_decode (
        .clkin     (clkin),
        .resetn    (resetn),
        .wb_adr_i  (wb_adr_i),
        .wb_dat_i  (wb_dat_i),
        .wb_sel_i  (wb_sel_i),
        .wb_we_i   (wb_we_i),
        .wb_cyc_i  (wb_cyc_i),
        .wb_stb_i  (wb_stb_i),
        .wb_ack_o  (wb_ack_o),
        .wb_dat_o  (wb_dat_o),
        .low_wr_o  (low_wr),
        .high_wr_o (high_wr),
        .low_rd_i  (low_rd),
        .high_rd_i (high_rd)
    );

    counter_timer_low i_low (
        .clkin  (clkin),
        .resetn (resetn),
        .wr_i   (low_wr),
        .rd_o   (low_rd),
        .link_i (high_link),
        .link_o (low_link),
        .irq_o  (irq_o[0])
    );

    counter_timer_high i_high (
        .clkin  (clkin),
        .resetn (resetn),
        .wr_i   (high_wr),
        .rd_o   (high_rd),
        .link_i (low_link),
        .link_o (high_link),
        .irq_o  (irq_o[1])
    );

endmodule

//--- src/timer_bus_decode.sv
`timescale 1ns/1ps

module timer_bus_decode import timer_pkg::*; #(
    parameter adr_t base_adr = BASE_ADR
) (
    input  logic      clkin,
    input  logic      resetn,
    input  adr_t      wb_adr_i,
    input  word_t     wb_dat_i,
    input  byte_en_t  wb_sel_i,
    input  logic      wb_we_i,
    input  logic      wb_cyc_i,
    input  logic      wb_stb_i,
    output logic      wb_ack_o,
    output word_t     wb_dat_o,
    output timer_wr_t low_wr_o,
    output timer_wr_t high_wr_o,
    input  timer_rd_t low_rd_i,
    input  timer_rd_t high_rd_i
);

    logic     valid;
    byte_en_t wr_lanes;
    logic     low_cfg_sel;
    logic     low_val_sel;
    logic     low_dat_sel;
    logic     high_cfg_sel;
    logic     high_val_sel;
    logic     high_dat_sel;

    assign valid    = wb_stb_i && wb_cyc_i;
    assign wr_lanes = wb_sel_i & {4{wb_we_i}};  // Lanes only count on a write

    // Full address compare, no aliasing
    assign low_cfg_sel  = valid && (wb_adr_i == base_adr + CFG_OFS);
    assign low_val_sel  = valid && (wb_adr_i == base_adr + VAL_OFS);
    assign low_dat_sel  = valid && (wb_adr_i == base_adr + DAT_OFS);
    assign high_cfg_sel = valid && (wb_adr_i == base_adr + HIGH_OFS + CFG_OFS);
    assign high_val_sel = valid && (wb_adr_i == base_adr + HIGH_OFS + VAL_OFS);
    assign high_dat_sel = valid && (wb_adr_i == base_adr + HIGH_OFS + DAT_OFS);

    assign low_wr_o.cfg_we  = low_cfg_sel & wb_sel_i[0] & wb_we_i;  // Config lives in lane 0
    assign low_wr_o.val_we  = low_val_sel ? wr_lanes : '0;
    assign low_wr_o.dat_we  = low_dat_sel ? wr_lanes : '0;
    assign low_wr_o.wdata   = wb_dat_i;
    assign high_wr_o.cfg_we = high_cfg_sel & wb_sel_i[0] & wb_we_i;
    assign high_wr_o.val_we = high_val_sel ? wr_lanes : '0;
    assign high_wr_o.dat_we = high_dat_sel ? wr_lanes : '0;
    assign high_wr_o.wdata  = wb_dat_i;

    // Read mux, zero when nothing is mapped
    always_comb begin
        wb_dat_o = '0;
        if (low_cfg_sel) begin
            wb_dat_o = low_rd_i.cfg_rd;
        end else if (low_val_sel) begin
            wb_dat_o = low_rd_i.val_rd;
        end else if (low_dat_sel) begin
            wb_dat_o = low_rd_i.dat_rd;
        end else if (high_cfg_sel) begin
            wb_dat_o = high_rd_i.cfg_rd;
        end else if (high_val_sel) begin
            wb_dat_o = high_rd_i.val_rd;
        end else if (high_dat_sel) begin
            wb_dat_o = high_rd_i.dat_rd;
        end
    end

    assign wb_ack_o = low_cfg_sel || low_val_sel || low_dat_sel ||
                      high_cfg_sel || high_val_sel || high_dat_sel;  // Zero wait states

    // Register map must never select two registers at once
    a_one_sel: assert property (@(posedge clkin) disable iff (!resetn)
        $onehot0({low_cfg_sel, low_val_sel, low_dat_sel,
                  high_cfg_sel, high_val_sel, high_dat_sel}));

endmodule

//--- src/timer_pkg.sv
package timer_pkg;

    typedef logic [31:0] word_t;     // Register value and bus data
    typedef logic [31:0] adr_t;      // Wishbone byte address
    typedef logic [3:0]  byte_en_t;  // One enable per byte lane

    localparam adr_t BASE_ADR = 32'h2400_0000;  // Default base of the peripheral
    localparam adr_t CFG_OFS  = 32'h0000_0000;
    localparam adr_t VAL_OFS  = 32'h0000_0004;  // Reload / stop value
    localparam adr_t DAT_OFS  = 32'h0000_0008;  // Current count
    localparam adr_t HIGH_OFS = 32'h0000_0010;  // Start of the high timer group

    // Configuration bits, kept in register bits 4:0
    typedef struct packed {
        logic irq_ena;  // Pulse irq on the stop condition
        logic chain;    // Join with the other word as a 64-bit timer
        logic updown;   // 1 counts up, 0 counts down
        logic oneshot;  // Hold at the terminal value
        logic enable;
    } timer_cfg_t;

    // Write side of one timer's register group
    typedef struct packed {
        logic     cfg_we;
        byte_en_t val_we;
        byte_en_t dat_we;
        word_t    wdata;
    } timer_wr_t;

    typedef struct packed {
        word_t cfg_rd;
        word_t val_rd;
        word_t dat_rd;
    } timer_rd_t;

    // Low word to high word
    typedef struct packed {
        logic strobe;     // Early rollover, one cycle wide
        logic is_offset;  // High word stop value must be taken one lower
        logic enable;
    } low_link_t;

    // High word back to low word
    typedef struct packed {
        logic stop;       // High word sits at its terminal value
        logic enable;
    } high_link_t;

endpackage

//--- testbench/tb_counter_timer_tests.svh
// Readback through several lane masks, config width, unmapped holes
task automatic test_register_access();
    adr_t     regs[4];
    byte_en_t masks[4];
    word_t    expv[4];   // Last value written to each register
    word_t    v;
    word_t    rd;
    regs  = '{LOW_VAL, LOW_DAT, HIGH_VAL, HIGH_DAT};  // Timers idle, data regs hold
    masks = '{4'b0101, 4'b1010, 4'b0011, 4'b1100};
    for (int i = 0; i < 4; i++) begin
        v = word_t'($random(seed));
        bus_write(regs[i], v);
        bus_read(regs[i], rd);
        check_value("full word readback", rd, v);
        expv[i] = lane_merge(v, ~v, masks[i]);
        bus_write(regs[i], ~v, masks[i]);
        bus_read(regs[i], rd);
        check_value("byte lane readback", rd, expv[i]);
    end
    bus_write(LOW_CFG, 32'hFFFF_FFEA);          // Chain and oneshot, enable clear
    bus_read(LOW_CFG, rd);
    check_value("low cfg", rd, 32'h0000_000A);
    bus_write(LOW_CFG, 32'h0000_0015, 4'b1110); // No lane 0, no change
    bus_read(LOW_CFG, rd);
    check_value("low cfg lane 0 off", rd, 32'h0000_000A);
    bus_write(HIGH_CFG, 32'hFFFF_FFF4);
    bus_read(HIGH_CFG, rd);
    check_value("high cfg", rd, 32'h0000_0014);
    bus_write(LOW_CFG, 32'h0);
    bus_write(HIGH_CFG, 32'h0);
    unmapped_probe(BASE_ADR + 32'h0C);
    unmapped_probe(BASE_ADR + HIGH_OFS + 32'h0C);
    unmapped_probe(BASE_ADR - 32'h4);
    for (int i = 0; i < 4; i++) begin           // Unmapped writes must not alias
        bus_read(regs[i], rd);
        check_value("readback after unmapped writes", rd, expv[i]);
    end
    bus_read(LOW_CFG, rd);
    check_value("low cfg after unmapped writes", rd, 32'h0);
    bus_read(HIGH_CFG, rd);
    check_value("high cfg after unmapped writes", rd, 32'h0);
endtask

task automatic run_down_oneshot(word_t n, logic irq_on);
    word_t prev;
    word_t cur;
    int    reads;
    bus_write(LOW_CFG, 32'h0);
    bus_write(LOW_VAL, n);
    bus_write(LOW_DAT, n);                 // Keep the first reads from looking stale
    clear_irq_stats();
    bus_write(LOW_CFG, CFG_EN | CFG_ONESHOT | (irq_on ? CFG_IRQ : 32'h0));
    prev  = n;
    reads = 0;
    do begin
        bus_read(LOW_DAT, cur);
        expect_true(cur <= prev, "low down count increased");
        prev = cur;
        reads++;
        if (reads > POLL_LIMIT) report_error("low down count never reached zero");
    end while (cur != 32'h0);
    repeat (4) begin
        bus_read(LOW_DAT, cur);
        check_value("low dat held", cur, 32'h0);
    end
    wait_cycles(3);
    check_value("irq_o[0] pulses", word_t'(irq_pulses[0]), irq_on ? 32'h1 : 32'h0);
    if (irq_on) check_value("irq_o[0] width", word_t'(irq_width_max[0]), 32'h1);
    check_value("irq_o[1] pulses", word_t'(irq_pulses[1]), 32'h0);
    bus_write(LOW_CFG, 32'h0);
endtask

task automatic test_down_oneshot();
    run_down_oneshot(rand_range(32'd20, 32'hF), 1'b1);
    run_down_oneshot(rand_range(32'd20, 32'hF), 1'b0);
endtask

task automatic test_up_continuous();
    word_t p;
    word_t cur;
    p = rand_range(32'd8, 32'h7);
    bus_write(LOW_CFG, 32'h0);
    bus_write(LOW_VAL, p);
    bus_write(LOW_DAT, 32'h0);
    clear_irq_stats();
    bus_write(LOW_CFG, CFG_EN | CFG_UP | CFG_IRQ);
    repeat (2 * (int'(p) + 1)) begin       // Four periods of p + 1 cycles
        bus_read(LOW_DAT, cur);
        expect_true(cur <= p, "low up count passed its stop value");
    end
    expect_true(irq_pulses[0] >= 2, "too few interrupts in continuous up count");
    check_value("irq_o[0] width", word_t'(irq_width_max[0]), 32'h1);
    bus_write(LOW_CFG, 32'h0);
endtask

// Bus write to the data register beats the running count
task automatic test_data_priority();
    word_t cur;
    bus_write(LOW_VAL, 32'h0000_1000);
    bus_write(LOW_DAT, 32'h0000_1000);
    bus_write(LOW_CFG, CFG_EN);
    wait_cycles(5);
    bus_write(LOW_DAT, 32'h0000_0500);
    bus_read(LOW_DAT, cur);
    expect_true(cur <= 32'h0000_0500, "count above the written data value");
    expect_true(cur >= 32'h0000_04FC, "count did not take the written data value");
    bus_write(LOW_CFG, 32'h0);
endtask

task automatic test_chained_down();
    word_t l;
    word_t lo;
    word_t hi;
    int    reads;
    l = rand_range(32'd10, 32'hF);
    bus_write(LOW_VAL, l);
    bus_write(LOW_DAT, l);
    bus_write(HIGH_VAL, 32'h1);
    bus_write(HIGH_DAT, 32'h1);
    clear_irq_stats();
    bus_write(HIGH_CFG, CFG_CHAIN | CFG_EN | CFG_ONESHOT);
    bus_write(LOW_CFG, CFG_CHAIN | CFG_EN | CFG_ONESHOT | CFG_IRQ);  // Both start here
    reads = 0;
    do begin
        bus_read(LOW_DAT, lo);
        bus_read(HIGH_DAT, hi);             // Low word is two lower by now
        expect_true(hi <= 32'h1, "high word left its range");
        expect_true(lo < 32'd3 || hi == 32'h1, "high word moved before low rollover");
        reads++;
        if (reads > POLL_LIMIT) report_error("chained timer never reached zero");
    end while (lo != 32'h0 || hi != 32'h0);
    repeat (3) begin
        bus_read(LOW_DAT, lo);
        check_value("chained low dat", lo, 32'h0);
        bus_read(HIGH_DAT, hi);
        check_value("chained high dat", hi, 32'h0);
    end
    check_value("irq_o[0] pulses", word_t'(irq_pulses[0]), 32'h1);
    check_value("irq_o[1] pulses", word_t'(irq_pulses[1]), 32'h0);
    bus_write(LOW_CFG, 32'h0);
    bus_write(HIGH_CFG, 32'h0);
endtask

task automatic test_high_alone();
    word_t m;
    word_t low_snap;
    word_t prev;
    word_t cur;
    int    reads;
    m = rand_range(32'd20, 32'hF);
    low_snap = ~m;                          // Parked value the idle low word must keep
    bus_write(LOW_DAT, low_snap);
    bus_write(HIGH_VAL, m);
    bus_write(HIGH_DAT, m);
    clear_irq_stats();
    bus_write(HIGH_CFG, CFG_EN | CFG_ONESHOT | CFG_IRQ);
    prev  = m;
    reads = 0;
    do begin
        bus_read(HIGH_DAT, cur);
        expect_true(cur <= prev, "high down count increased");
        prev = cur;
        reads++;
        if (reads > POLL_LIMIT) report_error("high timer never reached zero");
    end while (cur != 32'h0);
    wait_cycles(3);
    bus_read(LOW_DAT, cur);
    check_value("low dat untouched", cur, low_snap);
    check_value("irq_o[1] pulses", word_t'(irq_pulses[1]), 32'h1);
    check_value("irq_o[1] width", word_t'(irq_width_max[1]), 32'h1);
    check_value("irq_o[0] pulses", word_t'(irq_pulses[0]), 32'h0);
    bus_write(HIGH_CFG, 32'h0);
endtask

//--- testbench/tb_counter_timer.sv
`timescale 1ns/1ps

module tb_counter_timer import timer_pkg::*; ();

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int ACK_LIMIT    = 4;     // Zero-wait slave, ack is expected at once
    localparam int POLL_LIMIT   = 64;    // Reads allowed before a count must settle

    // Cycle budget per test, each bus access takes two cycles
    localparam int REGS_CYCLES   = 120;
    localparam int DOWN_CYCLES   = 2 * 200;
    localparam int UP_CYCLES     = 200;
    localparam int PRIO_CYCLES   = 60;
    localparam int CHAIN_CYCLES  = 160;
    localparam int ALONE_CYCLES  = 160;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + REGS_CYCLES + DOWN_CYCLES + UP_CYCLES +
                                    PRIO_CYCLES + CHAIN_CYCLES + ALONE_CYCLES + 200;

    // Register map as given by the bus layout
    localparam adr_t LOW_CFG  = BASE_ADR + CFG_OFS;
    localparam adr_t LOW_VAL  = BASE_ADR + VAL_OFS;
    localparam adr_t LOW_DAT  = BASE_ADR + DAT_OFS;
    localparam adr_t HIGH_CFG = BASE_ADR + HIGH_OFS + CFG_OFS;
    localparam adr_t HIGH_VAL = BASE_ADR + HIGH_OFS + VAL_OFS;
    localparam adr_t HIGH_DAT = BASE_ADR + HIGH_OFS + DAT_OFS;

    // Configuration bits
    localparam word_t CFG_EN      = 32'h01;
    localparam word_t CFG_ONESHOT = 32'h02;
    localparam word_t CFG_UP      = 32'h04;
    localparam word_t CFG_CHAIN   = 32'h08;
    localparam word_t CFG_IRQ     = 32'h10;

    logic       clkin;
    logic       resetn;
    adr_t       wb_adr_i;
    word_t      wb_dat_i;
    byte_en_t   wb_sel_i;
    logic       wb_we_i;
    logic       wb_cyc_i;
    logic       wb_stb_i;
    logic       wb_ack_o;
    word_t      wb_dat_o;
    logic [1:0] irq_o;

    integer     seed;
    int         cycle_count;
    int         irq_pulses[2];     // Rising edges seen per irq bit
    int         irq_run[2];
    int         irq_width_max[2];  // Longest pulse in cycles
    logic [1:0] irq_prev;

    counter_timer_top i_dut (
        .clkin    (clkin),
        .resetn   (resetn),
        .wb_adr_i (wb_adr_i),
        .wb_dat_i (wb_dat_i),
        .wb_sel_i (wb_sel_i),
        .wb_we_i  (wb_we_i),
        .wb_cyc_i (wb_cyc_i),
        .wb_stb_i (wb_stb_i),
        .wb_ack_o (wb_ack_o),
        .wb_dat_o (wb_dat_o),
        .irq_o    (irq_o)
    );

    initial begin
        clkin = 1'b0;
        forever #(CLK_PERIOD / 2) clkin = ~clkin;
    end

    task automatic abort_run();
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic report_error(string what);
        $display("ERROR: %s", what);
        abort_run();
    endtask

    task automatic check_value(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic expect_true(logic cond, string what);
        if (cond !== 1'b1) begin
            report_error(what);
        end
    endtask

    // Run limit
    always @(posedge clkin) begin
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            report_error("simulation ran past its cycle limit");
        end
    end

    // Irq pulse counting, sampled away from the active edge
    always @(negedge clkin) begin
        for (int b = 0; b < 2; b++) begin
            if (irq_o[b]) begin
                irq_run[b]++;
                if (!irq_prev[b]) irq_pulses[b]++;
            end else begin
                irq_run[b] = 0;
            end
            if (irq_run[b] > irq_width_max[b]) irq_width_max[b] = irq_run[b];
        end
        irq_prev = irq_o;
    end

    task automatic clear_irq_stats();
        @(posedge clkin);
        irq_pulses    = '{0, 0};
        irq_width_max = '{0, 0};
    endtask

    task automatic wait_cycles(int n);
        repeat (n) @(negedge clkin);
    endtask

    // One Wishbone cycle, two clocks including the idle one
    task automatic bus_access(adr_t adr, word_t data, byte_en_t sel, logic we,
                              output word_t rdata);
        int waited;
        @(negedge clkin);
        wb_adr_i = adr;
        wb_dat_i = data;
        wb_sel_i = sel;
        wb_we_i  = we;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        #(CLK_PERIOD / 4);
        waited = 0;
        while (!wb_ack_o && waited < ACK_LIMIT) begin
            @(posedge clkin);
            #(CLK_PERIOD / 4);
            waited++;
        end
        if (!wb_ack_o) report_error("Wishbone slave never acknowledged the access");
        rdata = wb_dat_o;
        @(posedge clkin);                // Write lands here
        @(negedge clkin);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    task automatic bus_write(adr_t adr, word_t data, byte_en_t sel = 4'hF);
        word_t unused;
        bus_access(adr, data, sel, 1'b1, unused);
    endtask

    task automatic bus_read(adr_t adr, output word_t data);
        bus_access(adr, 32'h0, 4'hF, 1'b0, data);
    endtask

    // Unmapped address, must stay silent for reads and writes
    task automatic unmapped_probe(adr_t adr);
        @(negedge clkin);
        wb_adr_i = adr;
        wb_dat_i = 32'hFFFF_FFFF;
        wb_sel_i = 4'hF;
        wb_we_i  = 1'b1;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        #(CLK_PERIOD / 4);
        check_value("wb_ack_o unmapped", word_t'(wb_ack_o), 32'h0);
        check_value("wb_dat_o unmapped", wb_dat_o, 32'h0);
        @(posedge clkin);
        @(negedge clkin);
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
    endtask

    // Byte lanes with sel set take the new data
    function automatic word_t lane_merge(word_t old, word_t data, byte_en_t sel);
        word_t res;
        res = old;
        for (int i = 0; i < 4; i++) begin
            if (sel[i]) res[8*i +: 8] = data[8*i +: 8];
        end
        return res;
    endfunction

    function automatic word_t rand_range(word_t lo, word_t mask);
        return lo + (word_t'($random(seed)) & mask);
    endfunction

    `include "tb_counter_timer_tests.svh"

    initial begin
        seed          = 74;
        cycle_count   = 0;
        irq_pulses    = '{0, 0};
        irq_run       = '{0, 0};
        irq_width_max = '{0, 0};
        irq_prev      = 2'b00;
        resetn        = 1'b0;
        wb_adr_i      = '0;
        wb_dat_i      = '0;
        wb_sel_i      = '0;
        wb_we_i       = 1'b0;
        wb_cyc_i      = 1'b0;
        wb_stb_i      = 1'b0;
        wait_cycles(RESET_CYCLES);
        resetn = 1'b1;

        test_register_access();
        test_down_oneshot();
        test_up_continuous();
        test_data_priority();
        test_chained_down();
        test_high_alone();

        wait_cycles(2);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule
